// File: mania_pkg.sv
// shared widths, types, phase codes and stream tags of the rhythm game core
package mania_pkg;

	typedef logic [7:0] byte_t;          // stream and song bytes
	typedef logic [7:0] sel_t;           // song selection, stream init index

	typedef logic [14:0] skin_addr_t;
	typedef logic [15:0] skin_word_t;

	typedef logic [12:0] chart_addr_t;
	typedef logic [23:0] chart_word_t;

	// four chart addresses, entry k at bits 13k and up
	typedef logic [51:0] part_table_t;

	localparam int NUM_PARTS = 4;

	// aux info tags that pick the image on the prefetch stream
	localparam byte_t TAG_SKIN = 8'h80;
	localparam byte_t TAG_CHART = 8'h00;

	// codes read as BCD on the debug display
	typedef enum logic [15:0] {
		ph_init = 16'h0000,
		ph_load_skin = 16'h0001,
		ph_w_load_skin = 16'h0002,
		ph_load_chart = 16'h0003,
		ph_w_load_chart = 16'h0004,
		ph_reset_song = 16'h0011,
		ph_scan = 16'h0013,
		ph_w_scan = 16'h0014,
		ph_play = 16'h0100
	} phase_t;

endpackage

// File: section_loader.sv
// section loader, packs prefetch stream bytes into memory words and writes them in order
`timescale 1ns/10ps

module section_loader #(
	parameter int ADDR_W = 13,
	parameter int BYTES = 3,
	parameter mania_pkg::byte_t AUX_TAG = 8'h00
) (
	input logic CLK,
	input logic RESET_L,
	input logic start,
	input mania_pkg::sel_t song_selection,
	input mania_pkg::byte_t data_in,
	input logic data_ready,
	input logic transmit_finished,
	output logic restart,
	output mania_pkg::sel_t init_index,
	output mania_pkg::byte_t init_aux_info,
	output logic request_data,
	output logic [ADDR_W-1:0] wr_addr,
	output logic [8*BYTES-1:0] wr_data,
	output logic wr_en,
	output logic done
);
	localparam int WORD_W = 8 * BYTES;
	localparam int CNT_W = $clog2(BYTES + 1);

	typedef enum logic [1:0] {
		ld_idle,
		ld_restart,
		ld_req,    // end check, then ask for one byte
		ld_wait
	} ld_state_t;

	ld_state_t state;
	logic [CNT_W-1:0] byte_cnt;  // bytes already in the word
	logic [WORD_W-1:0] shift_q;
	logic last_byte;

	assign init_index = song_selection;
	assign init_aux_info = AUX_TAG;
	assign restart = (state == ld_restart);
	assign request_data = (state == ld_req) && !transmit_finished;
	assign done = (state == ld_req) && transmit_finished && (byte_cnt == '0);
	assign last_byte = (byte_cnt == CNT_W'(BYTES - 1));
	assign wr_data = shift_q;

	always_ff @(posedge CLK) begin
		if (!RESET_L) begin
			state <= ld_idle;
			byte_cnt <= '0;
			wr_addr <= '0;
			wr_en <= 1'b0;
		end else begin
			wr_en <= 1'b0;
			if (wr_en)
				wr_addr <= wr_addr + 1'b1;
			case (state)
				ld_idle: begin
					if (start) begin
						state <= ld_restart;
						byte_cnt <= '0;
						wr_addr <= '0;
					end
				end
				ld_restart: state <= ld_req;
				ld_req: begin
					if (!transmit_finished)
						state <= ld_wait;
					else if (byte_cnt == '0)
						state <= ld_idle;
					// a truncated word keeps the loader parked here
				end
				ld_wait: begin
					if (data_ready) begin
						state <= ld_req;
						if (last_byte) begin
							byte_cnt <= '0;
							wr_en <= 1'b1;  // word complete
						end else begin
							byte_cnt <= byte_cnt + 1'b1;
						end
					end
				end
				default: state <= ld_idle;
			endcase
		end
	end

	// first byte ends up in the low byte
	always_ff @(posedge CLK) begin
		if (state == ld_wait && data_ready)
			shift_q <= (shift_q >> 8) | (WORD_W'(data_in) << (WORD_W - 8));
	end

endmodule

// File: part_table_scanner.sv
// chart part table scanner, reads the four part headers and builds the size and base tables
`timescale 1ns/10ps

module part_table_scanner (
	input logic CLK,
	input logic RESET_L,
	input logic start,
	input mania_pkg::chart_word_t rd_data,
	output mania_pkg::chart_addr_t rd_addr,
	output logic rd_en,
	output mania_pkg::part_table_t part_size,
	output mania_pkg::part_table_t part_base,
	output logic done
);
	import mania_pkg::*;

	localparam int PART_W = $clog2(NUM_PARTS);
	localparam int AW = $bits(chart_addr_t);

	logic active;
	logic [1:0] step;            // 0 address out .. 3 sample
	logic [PART_W-1:0] part;
	chart_addr_t hdr_size;
	logic sample;
	logic last_part;

	assign hdr_size = rd_data[AW-1:0];  // upper bits of the header unused
	assign sample = active && (step == 2'd3);
	assign last_part = (part == PART_W'(NUM_PARTS - 1));

	always_ff @(posedge CLK) begin
		if (!RESET_L) begin
			active <= 1'b0;
			step <= '0;
			part <= '0;
			rd_addr <= '0;
			rd_en <= 1'b0;
			part_size <= '0;
			part_base <= '0;
			done <= 1'b0;
		end else begin
			done <= sample && last_part;
			if (start && !active) begin
				active <= 1'b1;
				step <= '0;
				part <= '0;
				rd_addr <= '0;  // header 0
				rd_en <= 1'b1;
			end else if (active) begin
				step <= step + 1'b1;
				if (sample) begin
					part_size[AW*part +: AW] <= hdr_size;
					part_base[AW*part +: AW] <= rd_addr + 1'b1;
					// next header sits right behind this part's body
					rd_addr <= rd_addr + hdr_size + 1'b1;
					part <= part + 1'b1;
					if (last_part) begin
						active <= 1'b0;
						rd_en <= 1'b0;
					end
				end
			end
		end
	end

endmodule

// File: phase_sequencer.sv
// boot phase sequencer, steps through loading, song restart and scan, and owns the prefetch stream
`timescale 1ns/10ps

module phase_sequencer (
	input logic CLK,
	input logic RESET_L,
	input mania_pkg::sel_t song_selection,
	input logic skin_done,
	input logic chart_done,
	input logic scan_done,
	input mania_pkg::sel_t skin_index,
	input mania_pkg::byte_t skin_aux,
	input logic skin_req,
	input logic skin_restart,
	input mania_pkg::sel_t chart_index,
	input mania_pkg::byte_t chart_aux,
	input logic chart_req,
	input logic chart_restart,
	output mania_pkg::phase_t phase,
	output logic skin_start,
	output logic chart_start,
	output logic scan_start,
	output logic play_on,
	output mania_pkg::sel_t pre_init_index,
	output mania_pkg::byte_t pre_init_aux_info,
	output logic pre_request_data,
	output logic pre_restart,
	output logic song_restart,
	output mania_pkg::sel_t song_init_index,
	output mania_pkg::byte_t song_init_aux_info
);
	import mania_pkg::*;

	phase_t next_phase;

	always_ff @(posedge CLK) begin
		if (!RESET_L)
			phase <= ph_init;
		else
			phase <= next_phase;
	end

	always_comb begin
		next_phase = phase;
		case (phase)
			ph_init: next_phase = ph_load_skin;
			ph_load_skin: next_phase = ph_w_load_skin;
			ph_w_load_skin: if (skin_done) next_phase = ph_load_chart;
			ph_load_chart: next_phase = ph_w_load_chart;
			ph_w_load_chart: if (chart_done) next_phase = ph_reset_song;
			ph_reset_song: next_phase = ph_scan;
			ph_scan: next_phase = ph_w_scan;
			ph_w_scan: if (scan_done) next_phase = ph_play;
			ph_play: next_phase = ph_play;  // runs until reset
			default: next_phase = ph_init;
		endcase
	end

	assign skin_start = (phase == ph_load_skin);
	assign chart_start = (phase == ph_load_chart);
	assign scan_start = (phase == ph_scan);
	assign play_on = (phase == ph_play);

	// song stream restarts once, plain selection with no tag
	assign song_restart = (phase == ph_reset_song);
	assign song_init_index = song_selection;
	assign song_init_aux_info = '0;

	// stream owner follows the load phase pair
	always_comb begin
		pre_init_index = '0;
		pre_init_aux_info = '0;
		pre_request_data = 1'b0;
		pre_restart = 1'b0;
		case (phase)
			ph_load_skin, ph_w_load_skin: begin
				pre_init_index = skin_index;
				pre_init_aux_info = skin_aux;
				pre_request_data = skin_req;
				pre_restart = skin_restart;
			end
			ph_load_chart, ph_w_load_chart: begin
				pre_init_index = chart_index;
				pre_init_aux_info = chart_aux;
				pre_request_data = chart_req;
				pre_restart = chart_restart;
			end
			default: ;
		endcase
	end

endmodule

// File: play_timer.sv
// play timer, update tick, audio sample pacing after the start-up delay, audio output latch
`timescale 1ns/10ps

module play_timer #(
	parameter int UPDATE_PERIOD = 10,
	parameter int AUDIO_PERIOD = 7,
	parameter int PLAY_DELAY = 3
) (
	input logic CLK,
	input logic RESET_L,
	input logic play_on,
	input mania_pkg::byte_t song_data_in,
	input logic song_data_ready,
	output logic update_tick,
	output logic song_request_data,
	output mania_pkg::byte_t main_audio_out,
	output logic audio_en
);
	localparam int UPD_W = $clog2(UPDATE_PERIOD + 1);
	localparam int AUD_W = $clog2(AUDIO_PERIOD + 1);
	localparam int DLY_W = $clog2(PLAY_DELAY + 2);

	logic [UPD_W-1:0] update_cnt;
	logic [AUD_W-1:0] audio_cnt;
	logic [DLY_W-1:0] delay_cnt;  // wraps seen so far, saturates at PLAY_DELAY
	logic audio_wrap;

	assign update_tick = play_on && (update_cnt == UPD_W'(UPDATE_PERIOD - 1));
	assign audio_wrap = play_on && (audio_cnt == AUD_W'(AUDIO_PERIOD - 1));
	assign audio_en = play_on;

	always_ff @(posedge CLK) begin
		if (!RESET_L) begin
			update_cnt <= '0;
			audio_cnt <= '0;
		end else if (play_on) begin
			update_cnt <= update_tick ? '0 : update_cnt + 1'b1;
			audio_cnt <= audio_wrap ? '0 : audio_cnt + 1'b1;
		end
	end

	// one request per audio period once the delay has run out
	always_ff @(posedge CLK) begin
		if (!RESET_L) begin
			delay_cnt <= '0;
			song_request_data <= 1'b0;
		end else begin
			if (audio_wrap && delay_cnt < DLY_W'(PLAY_DELAY))
				delay_cnt <= delay_cnt + 1'b1;
			song_request_data <= audio_wrap && (delay_cnt == DLY_W'(PLAY_DELAY));
		end
	end

	always_ff @(posedge CLK) begin
		if (!RESET_L)
			main_audio_out <= '0;  // silent until the first sample
		else if (song_data_ready)
			main_audio_out <= song_data_in;
	end

endmodule

// File: game_core.sv
// game core top, boot loaders, part table scan, phase sequencer and play timing
`timescale 1ns/10ps

module game_core #(
	parameter int UPDATE_PERIOD = 100000,
	parameter int AUDIO_PERIOD = 2267,
	parameter int PLAY_DELAY = 66150
) (
	input logic CLK,
	input logic RESET_L,
	input mania_pkg::sel_t song_selection,
	output mania_pkg::sel_t pre_init_index,
	output mania_pkg::byte_t pre_init_aux_info,
	output logic pre_request_data,
	output logic pre_restart,
	input mania_pkg::byte_t pre_data_in,
	input logic pre_data_ready,
	input logic pre_transmit_finished,
	output mania_pkg::sel_t song_init_index,
	output mania_pkg::byte_t song_init_aux_info,
	output logic song_request_data,
	output logic song_restart,
	input mania_pkg::byte_t song_data_in,
	input logic song_data_ready,
	output mania_pkg::skin_addr_t skin_addr,
	output mania_pkg::skin_word_t skin_data,
	output logic skin_en_w,
	output mania_pkg::chart_addr_t chart_a_addr,
	output mania_pkg::chart_word_t chart_a_data,
	output logic chart_a_en_w,
	output mania_pkg::chart_addr_t chart_b_addr,
	output logic chart_b_en,
	input mania_pkg::chart_word_t chart_b_data,
	output mania_pkg::part_table_t part_size,
	output mania_pkg::part_table_t part_base,
	output logic update_tick,
	output mania_pkg::byte_t main_audio_out,
	output logic audio_en,
	output mania_pkg::phase_t debug_state
);
	import mania_pkg::*;

	logic skin_start, chart_start, scan_start, play_on;
	logic skin_done, chart_done, scan_done;
	sel_t skin_index, chart_index;
	byte_t skin_aux, chart_aux;
	logic skin_req, skin_restart;
	logic chart_req, chart_restart;

	section_loader #(.ADDR_W(15), .BYTES(2), .AUX_TAG(TAG_SKIN)) u_skin_loader (
		.CLK(CLK), .RESET_L(RESET_L), .start(skin_start), .song_selection(song_selection),
		.data_in(pre_data_in), .data_ready(pre_data_ready),
		.transmit_finished(pre_transmit_finished), .restart(skin_restart),
		.init_index(skin_index), .init_aux_info(skin_aux), .request_data(skin_req),
		.wr_addr(skin_addr), .wr_data(skin_data), .wr_en(skin_en_w), .done(skin_done)
	);

	section_loader #(.ADDR_W(13), .BYTES(3), .AUX_TAG(TAG_CHART)) u_chart_loader (
		.CLK(CLK), .RESET_L(RESET_L), .start(chart_start), .song_selection(song_selection),
		.data_in(pre_data_in), .data_ready(pre_data_ready),
		.transmit_finished(pre_transmit_finished), .restart(chart_restart),
		.init_index(chart_index), .init_aux_info(chart_aux), .request_data(chart_req),
		.wr_addr(chart_a_addr), .wr_data(chart_a_data), .wr_en(chart_a_en_w), .done(chart_done)
	);

	part_table_scanner u_part_table_scanner (
		.CLK(CLK), .RESET_L(RESET_L), .start(scan_start), .rd_data(chart_b_data),
		.rd_addr(chart_b_addr), .rd_en(chart_b_en), .part_size(part_size),
		.part_base(part_base), .done(scan_done)
	);

	phase_sequencer u_phase_sequencer (
		.CLK(CLK), .RESET_L(RESET_L), .song_selection(song_selection),
		.skin_done(skin_done), .chart_done(chart_done), .scan_done(scan_done),
		.skin_index(skin_index), .skin_aux(skin_aux), .skin_req(skin_req),
		.skin_restart(skin_restart), .chart_index(chart_index), .chart_aux(chart_aux),
		.chart_req(chart_req), .chart_restart(chart_restart), .phase(debug_state),
		.skin_start(skin_start), .chart_start(chart_start), .scan_start(scan_start),
		.play_on(play_on), .pre_init_index(pre_init_index),
		.pre_init_aux_info(pre_init_aux_info), .pre_request_data(pre_request_data),
		.pre_restart(pre_restart), .song_restart(song_restart),
		.song_init_index(song_init_index), .song_init_aux_info(song_init_aux_info)
	);

	play_timer #(
		.UPDATE_PERIOD(UPDATE_PERIOD),
		.AUDIO_PERIOD(AUDIO_PERIOD),
		.PLAY_DELAY(PLAY_DELAY)
	) u_play_timer (
		.CLK(CLK), .RESET_L(RESET_L), .play_on(play_on), .song_data_in(song_data_in),
		.song_data_ready(song_data_ready), .update_tick(update_tick),
		.song_request_data(song_request_data), .main_audio_out(main_audio_out),
		.audio_en(audio_en)
	);

endmodule

// File: game_core_props.sv
// game core assertions on the update tick, song request pacing and stream strobes
`timescale 1ns/10ps

module game_core_props (
	input logic CLK,
	input logic RESET_L,
	input logic update_tick,
	input logic song_request_data,
	input logic audio_en,
	input logic pre_request_data,
	input logic pre_restart
);

	// tick is a single cycle pulse
	property tick_single_cycle;
		@(posedge CLK) disable iff (!RESET_L)
			update_tick |=> !update_tick;
	endproperty

	property song_request_in_play;
		@(posedge CLK) disable iff (!RESET_L)
			song_request_data |-> audio_en;
	endproperty

	property stream_strobes_apart;
		@(posedge CLK) disable iff (!RESET_L)
			!(pre_request_data && pre_restart);
	endproperty

	assert_tick_single: assert property (tick_single_cycle)
		else $error("update_tick high on two consecutive cycles");
	assert_song_request: assert property (song_request_in_play)
		else $error("song_request_data raised outside play");
	assert_stream_strobes: assert property (stream_strobes_apart)
		else $error("pre_request_data and pre_restart high together");

endmodule

bind game_core game_core_props u_game_core_props (.*);

// File: tb_game_core.sv
// testbench for the game core, stream and song sources, chart memory model and checks
`timescale 1ns/10ps

module tb_game_core;
	import mania_pkg::*;

	localparam int UPDATE_PERIOD = 10;
	localparam int AUDIO_PERIOD = 7;
	localparam int PLAY_DELAY = 3;
	localparam int SKIN_BYTES = 40;
	localparam int PLAY_CYCLES = 100;
	localparam int FIRST_REQ = (PLAY_DELAY + 1) * AUDIO_PERIOD;

	logic CLK, RESET_L;
	sel_t song_selection, pre_init_index, song_init_index;
	byte_t pre_init_aux_info, song_init_aux_info, pre_data_in, song_data_in, main_audio_out;
	logic pre_request_data, pre_restart, pre_data_ready, pre_transmit_finished;
	logic song_request_data, song_restart, song_data_ready;
	skin_addr_t skin_addr;
	skin_word_t skin_data;
	logic skin_en_w, chart_a_en_w, chart_b_en, update_tick, audio_en;
	chart_addr_t chart_a_addr, chart_b_addr;
	chart_word_t chart_a_data, chart_b_data;
	part_table_t part_size, part_base;
	phase_t debug_state;

	byte_t skin_img [SKIN_BYTES];
	byte_t chart_img [128];
	chart_word_t chart_words [64];
	chart_word_t chart_mem [8192];
	byte_t song_tab [64];
	int delay_tab [256];
	logic [31:0] part_lens;       // one byte per part
	int chart_nwords, limit_cycles, cycle_cnt, check_cnt, play_cyc, audio_cnt;
	int err_cnt [1:6];
	logic play_done;

	game_core #(.UPDATE_PERIOD(UPDATE_PERIOD), .AUDIO_PERIOD(AUDIO_PERIOD),
		.PLAY_DELAY(PLAY_DELAY)) u_game_core (.*);

	// sizes and bases, header k right behind the body of part k-1
	function automatic logic [103:0] expected_tables(input logic [31:0] lens);
		part_table_t sizes;
		part_table_t bases;
		int addr;
		sizes = '0;
		bases = '0;
		addr = 0;
		for (int k = 0; k < NUM_PARTS; k++) begin
			sizes[13*k +: 13] = 13'(lens[8*k +: 8]);
			bases[13*k +: 13] = 13'(addr + 1);
			addr = addr + 1 + lens[8*k +: 8];
		end
		return {bases, sizes};
	endfunction

	task automatic compare_value(input int test_id, input string sig, input logic [63:0] got,
			input logic [63:0] exp);
		check_cnt++;
		if (got !== exp) begin
			err_cnt[test_id]++;
			$display("Fail %s: got %h expected %h", sig, got, exp);
		end
	endtask

	task automatic report_test(input int test_id, input string name);
		if (err_cnt[test_id] == 0)
			$display("test %0d %s: ok", test_id, name);
		else
			$display("test %0d %s: %0d errors", test_id, name, err_cnt[test_id]);
	endtask

	initial begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	initial begin : main_sequence
		int seed_dummy, len, total_err;
		seed_dummy = $urandom(88267);
		RESET_L = 1'b0;
		song_selection = 8'($urandom);
		pre_data_in = '0;
		pre_data_ready = 1'b0;
		pre_transmit_finished = 1'b0;
		song_data_in = '0;
		song_data_ready = 1'b0;
		chart_b_data = '0;
		play_done = 1'b0;
		{cycle_cnt, check_cnt, play_cyc, audio_cnt, total_err} = '0;
		for (int i = 1; i <= 6; i++)
			err_cnt[i] = 0;
		for (int i = 0; i < SKIN_BYTES; i++)
			skin_img[i] = 8'($urandom);
		chart_nwords = 0;
		for (int k = 0; k < NUM_PARTS; k++) begin
			len = $urandom_range(8, 1);
			part_lens[8*k +: 8] = 8'(len);
			chart_words[chart_nwords] = 24'(len);  // header holds the size
			chart_nwords++;
			for (int j = 0; j < len; j++) begin
				chart_words[chart_nwords] = 24'($urandom);
				chart_nwords++;
			end
		end
		for (int i = 0; i < chart_nwords; i++)
			for (int b = 0; b < 3; b++)
				chart_img[3*i+b] = chart_words[i][8*b +: 8];
		for (int i = 0; i < 256; i++)
			delay_tab[i] = $urandom_range(3, 0);
		for (int i = 0; i < 64; i++)
			song_tab[i] = 8'($urandom);
		limit_cycles = 8 * (SKIN_BYTES + 3 * chart_nwords) + 200;
		repeat (8) @(posedge CLK);
		#1 RESET_L = 1'b1;
		wait (play_done);
		if (audio_cnt == 0) begin
			err_cnt[6]++;
			$display("no song byte reached main_audio_out during play");
		end
		report_test(5, "play timing");
		report_test(6, "audio output");
		for (int i = 1; i <= 6; i++)
			total_err += err_cnt[i];
		$display("checks: %0d run, %0d failed", check_cnt, total_err);
		if (total_err == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

	initial begin : watchdog
		wait (limit_cycles > 0);
		while (cycle_cnt < limit_cycles)
			@(posedge CLK) cycle_cnt++;
		$display("timeout, play window not finished after %0d cycles", limit_cycles);
		$display("TEST FAILED");
		$finish;
	end

	// prefetch stream, image picked by the aux tag at restart
	initial begin : stream_source
		logic restart_seen, req_seen, pending, use_skin;
		byte_t aux;
		int ptr, len, wait_cnt, req_idx;
		{pending, use_skin, ptr, len, wait_cnt, req_idx} = '0;
		forever begin
			@(posedge CLK);
			restart_seen = RESET_L && pre_restart;
			req_seen = RESET_L && pre_request_data;
			aux = pre_init_aux_info;
			#1;
			pre_data_ready = 1'b0;
			if (restart_seen) begin
				use_skin = (aux == TAG_SKIN);
				len = use_skin ? SKIN_BYTES : 3 * chart_nwords;
				ptr = 0;
				pending = 1'b0;
				pre_transmit_finished = 1'b0;
			end
			if (req_seen) begin
				pending = 1'b1;
				wait_cnt = delay_tab[req_idx % 256];
				req_idx++;
			end else if (pending && wait_cnt > 0) begin
				wait_cnt--;
			end
			if (pending && wait_cnt == 0) begin
				pre_data_ready = 1'b1;
				pre_data_in = use_skin ? skin_img[ptr] : chart_img[ptr];
				ptr++;
				pre_transmit_finished = (ptr >= len);
				pending = 1'b0;
			end
		end
	end

	initial begin : song_source
		logic req_seen, answer_next;
		int song_idx;
		answer_next = 1'b0;
		song_idx = 0;
		forever begin
			@(posedge CLK);
			req_seen = RESET_L && song_request_data;
			#1;
			song_data_ready = answer_next;  // two cycles after the request
			if (answer_next) begin
				song_data_in = song_tab[song_idx % 64];
				song_idx++;
			end
			answer_next = req_seen;
		end
	end

	initial begin : chart_memory
		logic we, re;
		chart_addr_t wa, ra;
		chart_word_t wd;
		forever begin
			@(posedge CLK);
			{we, wa, wd} = {chart_a_en_w, chart_a_addr, chart_a_data};
			{re, ra} = {chart_b_en, chart_b_addr};
			#1;
			if (we === 1'b1)
				chart_mem[wa] = wd;
			if (re === 1'b1)
				chart_b_data = chart_mem[ra];  // one cycle read
		end
	end

	initial begin : response_check
		int skin_cnt, chart_cnt, restart_cnt, song_restart_cnt;
		logic audio_pending, skin_reported;
		byte_t audio_exp;
		logic [103:0] tables;
		{skin_cnt, chart_cnt, restart_cnt, song_restart_cnt} = '0;
		{audio_pending, skin_reported, audio_exp} = '0;
		forever begin
			@(posedge CLK);
			if (RESET_L === 1'b1 && !play_done) begin
				if (skin_en_w && skin_cnt < SKIN_BYTES / 2) begin
					compare_value(1, "skin_addr", skin_addr, skin_cnt);
					compare_value(1, "skin_data", skin_data,
						{skin_img[2*skin_cnt+1], skin_img[2*skin_cnt]});
				end
				skin_cnt += skin_en_w;
				if (chart_a_en_w && chart_cnt < chart_nwords) begin
					compare_value(2, "chart_a_addr", chart_a_addr, chart_cnt);
					compare_value(2, "chart_a_data", chart_a_data, chart_words[chart_cnt]);
				end
				chart_cnt += chart_a_en_w;
				if (pre_restart) begin
					compare_value(3, "pre_init_index", pre_init_index, song_selection);
					compare_value(3, "pre_init_aux_info", pre_init_aux_info,
						(restart_cnt == 0) ? TAG_SKIN : TAG_CHART);
					restart_cnt++;
				end
				if (song_restart) begin
					compare_value(3, "song_init_index", song_init_index, song_selection);
					compare_value(3, "song_init_aux_info", song_init_aux_info, 0);
					song_restart_cnt++;
				end
				if (debug_state == ph_load_chart && !skin_reported) begin
					compare_value(1, "skin write count", skin_cnt, SKIN_BYTES / 2);
					report_test(1, "skin load");
					skin_reported = 1'b1;
				end
				if (audio_pending) begin
					compare_value(6, "main_audio_out", main_audio_out, audio_exp);
					audio_cnt++;
				end
				audio_pending = song_data_ready;
				audio_exp = song_data_in;
				if (debug_state == ph_play) begin
					if (play_cyc == 0) begin
						tables = expected_tables(part_lens);
						compare_value(2, "chart write count", chart_cnt, chart_nwords);
						compare_value(3, "pre_restart count", restart_cnt, 2);
						compare_value(3, "song_restart count", song_restart_cnt, 1);
						compare_value(4, "part_size", part_size, tables[51:0]);
						compare_value(4, "part_base", part_base, tables[103:52]);
						report_test(2, "chart load");
						report_test(3, "stream restarts");
						report_test(4, "part tables");
					end
					compare_value(5, "audio_en", audio_en, 1);
					compare_value(5, "update_tick", update_tick,
						(play_cyc % UPDATE_PERIOD) == UPDATE_PERIOD - 1);
					compare_value(5, "song_request_data", song_request_data,
						play_cyc >= FIRST_REQ && (play_cyc - FIRST_REQ) % AUDIO_PERIOD == 0);
					play_cyc++;
					play_done = (play_cyc == PLAY_CYCLES);
				end else begin
					compare_value(5, "audio_en", audio_en, 0);  // silent during boot
					compare_value(5, "update_tick", update_tick, 0);
				end
			end
		end
	end

endmodule

// File: vlog.f
mania_pkg.sv
section_loader.sv
part_table_scanner.sv
phase_sequencer.sv
play_timer.sv
game_core.sv
game_core_props.sv
tb_game_core.sv
